// ==== bench/csr_stimulus.txt ====
# index_start index_end stride shift_left shift_amount route pause_cycles stall_mode
# All decimal except route (hex); stall_mode 1 drives req_ready from the LFSR
# Basic run
0 12 1 1 0 a5 0 0
# Left shift
100 160 3 1 4 3c 0 0
# Right shifts
65536 65600 5 0 3 71 0 0
305419896 305419960 8 0 12 e2 0 0
# Back-pressure, ranges longer than the FIFO
2000 2120 2 1 1 0f 0 1
7 400 9 0 2 c3 0 1
# Pause before configuration
50 80 1 1 3 5a 20 0
300 340 1 0 1 99 12 1
# Empty ranges
500 500 4 1 2 11 0 0
900 100 1 0 1 22 0 0
# Shift past the top bit
0 5 2 1 31 ff 0 0
# Range close to the top of the index space
4294967290 4294967295 2 1 1 44 0 0
# Short run with stalls to finish
10 30 1 0 0 6e 0 1

// ==== src.f ====
source/csr_index_pkg.sv
source/csr_request_pkg.sv
source/index_step_if.sv
source/request_push_if.sv
source/index_stride_counter.sv
source/index_sequencer.sv
source/request_fifo.sv
source/csr_index_generator.sv
bench/tb_csr_index_generator.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the CSR index generator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_csr_index_generator -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0

// ==== bench/tb_csr_index_generator.sv ====
// Testbench for the CSR index generator
// Stimulus file reader, reference model, LFSR stalls and watchdog
`timescale 1ns/10ps

module tb_csr_index_generator;
    import csr_index_pkg::*;
    import csr_request_pkg::*;

    logic       ap_clk = 1'b0;
    logic       areset_engine;
    logic       cfg_valid;
    logic       cfg_ready;
    index_t     cfg_index_start;
    index_t     cfg_index_end;
    stride_t    cfg_stride;
    logic       cfg_shift_left;
    shift_amt_t cfg_shift_amount;
    route_t     cfg_route;
    logic       pause;
    logic       req_valid;
    logic       req_ready;
    index_t     req_index;
    addr_t      req_base;
    addr_t      req_offset;
    route_t     req_route;
    logic       done;

    int          checks;
    int          errors;
    logic        timed_out;
    longint      timeout_cycles;
    logic [15:0] lfsr_state;

    // One entry per stimulus line
    index_t     st_start[$];
    index_t     st_end[$];
    stride_t    st_stride[$];
    logic       st_left[$];
    shift_amt_t st_amt[$];
    route_t     st_route[$];
    int         st_pause[$];
    int         st_stall[$];

    csr_index_generator #(
        .FIFO_DEPTH  (16),
        .PROG_THRESH (8)
    ) dut_i (
        .ap_clk           (ap_clk),
        .areset_engine    (areset_engine),
        .cfg_valid        (cfg_valid),
        .cfg_ready        (cfg_ready),
        .cfg_index_start  (cfg_index_start),
        .cfg_index_end    (cfg_index_end),
        .cfg_stride       (cfg_stride),
        .cfg_shift_left   (cfg_shift_left),
        .cfg_shift_amount (cfg_shift_amount),
        .cfg_route        (cfg_route),
        .pause            (pause),
        .req_valid        (req_valid),
        .req_ready        (req_ready),
        .req_index        (req_index),
        .req_base         (req_base),
        .req_offset       (req_offset),
        .req_route        (req_route),
        .done             (done)
    );

    initial begin
        forever #2 ap_clk = ~ap_clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int count_requests(input index_t first, input index_t last,
                                          input stride_t stride);
        longint idx;
        int     n;
        n = 0;
        for (idx = first; idx < last; idx += stride) n++;
        return n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            $display("%0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic read_stimulus();
        int         fd;
        string      line;
        index_t     a;
        index_t     b;
        stride_t    s;
        logic       l;
        shift_amt_t amt;
        route_t     r;
        int         p;
        int         m;
        fd = $fopen("bench/csr_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file bench/csr_stimulus.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#" &&
                    $sscanf(line, "%d %d %d %d %d %h %d %d", a, b, s, l, amt, r, p, m) == 8)
                begin
                    st_start.push_back(a);
                    st_end.push_back(b);
                    st_stride.push_back(s);
                    st_left.push_back(l);
                    st_amt.push_back(amt);
                    st_route.push_back(r);
                    st_pause.push_back(p);
                    st_stall.push_back(m);
                    timeout_cycles += 8 * count_requests(a, b, s) + p + 50;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_reset();
        repeat (5) begin
            @(negedge ap_clk);
            check_value("req_valid", req_valid, 0);
            check_value("cfg_ready", cfg_ready, 0);
            check_value("done", done, 0);
        end
        areset_engine = 1'b0;
        // First cycle out of reset is still quiet
        @(negedge ap_clk);
        check_value("req_valid", req_valid, 0);
        check_value("cfg_ready", cfg_ready, 0);
        check_value("done", done, 0);
    endtask

    // ------------------------------
    // One configuration run
    // ------------------------------
    task automatic run_line(input int n);
        index_t exp_idx[$];
        addr_t  exp_off[$];
        longint idx;
        int     cycles;
        logic   stalled;
        index_t held_idx;
        addr_t  held_base;
        addr_t  held_off;
        route_t held_route;
        for (idx = st_start[n]; idx < st_end[n]; idx += st_stride[n]) begin
            exp_idx.push_back(index_t'(idx));
            exp_off.push_back(st_left[n] ? index_t'(idx) << st_amt[n]
                                         : index_t'(idx) >> st_amt[n]);
        end
        while (!cfg_ready) @(negedge ap_clk);
        pause            = (st_pause[n] != 0);
        cfg_index_start  = st_start[n];
        cfg_index_end    = st_end[n];
        cfg_stride       = st_stride[n];
        cfg_shift_left   = st_left[n];
        cfg_shift_amount = st_amt[n];
        cfg_route        = st_route[n];
        cfg_valid        = 1'b1;
        @(negedge ap_clk);
        cfg_valid = 1'b0;
        check_value("cfg_ready", cfg_ready, 0);
        check_value("done", done, 0);
        cycles  = 0;
        stalled = 1'b0;
        do begin
            @(negedge ap_clk);
            cycles++;
            if (cycles >= st_pause[n]) pause = 1'b0;
            if (pause) check_true(!req_valid, "request appeared while pause was high");
            if (stalled) begin
                check_true(req_valid, "req_valid dropped while the request was stalled");
                check_value("req_index", req_index, held_idx);
                check_value("req_base", req_base, held_base);
                check_value("req_offset", req_offset, held_off);
                check_value("req_route", req_route, held_route);
            end
            if (st_stall[n] != 0) begin
                lfsr_state = lfsr_step(lfsr_state);
                req_ready  = lfsr_state[0];
            end else begin
                req_ready = 1'b1;
            end
            stalled    = req_valid && !req_ready;
            held_idx   = req_index;
            held_base  = req_base;
            held_off   = req_offset;
            held_route = req_route;
            if (req_valid && req_ready) begin
                if (exp_idx.size() == 0) begin
                    check_true(1'b0, "request received past the end of the range");
                end else begin
                    check_value("req_index", req_index, exp_idx.pop_front());
                    check_value("req_base", req_base, st_start[n]);
                    check_value("req_offset", req_offset, exp_off.pop_front());
                    check_value("req_route", req_route, st_route[n]);
                end
            end
        end while (!done);
        check_true(exp_idx.size() == 0, "run finished with expected requests missing");
        check_value("cfg_ready", cfg_ready, 1);
    endtask

    task automatic report_and_finish();
        $display("Checks: %0d  errors: %0d  timeout: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    initial begin
        areset_engine    = 1'b1;
        cfg_valid        = 1'b0;
        cfg_index_start  = '0;
        cfg_index_end    = '0;
        cfg_stride       = '0;
        cfg_shift_left   = 1'b0;
        cfg_shift_amount = '0;
        cfg_route        = '0;
        pause            = 1'b0;
        req_ready        = 1'b0;
        checks           = 0;
        errors           = 0;
        timed_out        = 1'b0;
        lfsr_state       = 16'd74;
        read_stimulus();
        apply_reset();
        for (int n = 0; n < st_start.size(); n++) run_line(n);
        report_and_finish();
    end

    // Watchdog sized from the stimulus file
    initial begin
        wait (timeout_cycles != 0);
        #(timeout_cycles * 4);
        $display("Timeout after %0d cycles, the run did not finish", timeout_cycles);
        timed_out = 1'b1;
        report_and_finish();
    end

endmodule

// ==== source/csr_index_generator.sv ====
// CSR edge-index generator top level
// Sequencer, stride counter and request FIFO on plain ports
`timescale 1ns/10ps

module csr_index_generator #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic                        ap_clk,
    input  logic                        areset_engine,
    // Run configuration
    input  logic                        cfg_valid,
    output logic                        cfg_ready,
    input  csr_index_pkg::index_t       cfg_index_start,
    input  csr_index_pkg::index_t       cfg_index_end,
    input  csr_index_pkg::stride_t      cfg_stride,
    input  logic                        cfg_shift_left,
    input  csr_index_pkg::shift_amt_t   cfg_shift_amount,
    input  csr_request_pkg::route_t     cfg_route,
    input  logic                        pause,
    // Request stream
    output logic                        req_valid,
    input  logic                        req_ready,
    output csr_index_pkg::index_t       req_index,
    output csr_request_pkg::addr_t      req_base,
    output csr_request_pkg::addr_t      req_offset,
    output csr_request_pkg::route_t     req_route,
    output logic                        done
);

    logic fifo_empty;

    index_step_if   step_if ();
    request_push_if push_if ();

    index_sequencer sequencer_i (
        .ap_clk           (ap_clk),
        .areset_engine    (areset_engine),
        .cfg_valid        (cfg_valid),
        .cfg_ready        (cfg_ready),
        .cfg_index_start  (cfg_index_start),
        .cfg_index_end    (cfg_index_end),
        .cfg_stride       (cfg_stride),
        .cfg_shift_left   (cfg_shift_left),
        .cfg_shift_amount (cfg_shift_amount),
        .cfg_route        (cfg_route),
        .pause            (pause),
        .fifo_empty       (fifo_empty),
        .done             (done),
        .step_if          (step_if.sequencer),
        .push_if          (push_if.sequencer)
    );

    index_stride_counter counter_i (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .step_if       (step_if.counter)
    );

    request_fifo #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .PROG_THRESH (PROG_THRESH)
    ) fifo_i (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .push_if       (push_if.fifo),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_index     (req_index),
        .req_base      (req_base),
        .req_offset    (req_offset),
        .req_route     (req_route),
        .fifo_empty    (fifo_empty)
    );

endmodule

// ==== source/request_fifo.sv ====
// Synchronous request FIFO with registered threshold flag
// Valid/ready pop on the output side
`timescale 1ns/10ps

module request_fifo #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic                        ap_clk,
    input  logic                        areset_engine,
    request_push_if.fifo                push_if,
    output logic                        req_valid,
    input  logic                        req_ready,
    output csr_index_pkg::index_t       req_index,
    output csr_request_pkg::addr_t      req_base,
    output csr_request_pkg::addr_t      req_offset,
    output csr_request_pkg::route_t     req_route,
    output logic                        fifo_empty
);
    import csr_index_pkg::*;
    import csr_request_pkg::*;

    localparam int PTR_W   = $clog2(FIFO_DEPTH);
    localparam int ENTRY_W = $bits(index_t) + 2 * $bits(addr_t) + $bits(route_t);

    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic [PTR_W:0]     count_next;
    logic               pop;

    assign pop = req_valid & req_ready;

    always_ff @(posedge ap_clk) begin
        if (push_if.push) begin
            mem[wr_ptr] <= {push_if.index, push_if.base, push_if.offset, push_if.route};
        end
    end

    always_comb begin
        unique case ({push_if.push, pop})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            wr_ptr               <= '0;
            rd_ptr               <= '0;
            count                <= '0;
            push_if.above_thresh <= 1'b0;
        end else begin
            if (push_if.push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count                <= count_next;
            push_if.above_thresh <= (count_next > PROG_THRESH);
        end
    end

    // Head entry read straight from storage
    assign {req_index, req_base, req_offset, req_route} = mem[rd_ptr];
    assign req_valid  = (count != '0);
    assign fifo_empty = (count == '0);

    // Sequencer throttling must leave room for the in-flight push
    assert property (@(posedge ap_clk) disable iff (areset_engine)
        push_if.push |-> count < FIFO_DEPTH);

    assert property (@(posedge ap_clk) disable iff (areset_engine)
        req_valid && !req_ready |=>
            req_valid && $stable({req_index, req_base, req_offset, req_route}));

endmodule

// ==== source/index_sequencer.sv ====
// Control FSM for the index generator
// Configuration register, request formation and status outputs
`timescale 1ns/10ps

module index_sequencer (
    input  logic                        ap_clk,
    input  logic                        areset_engine,
    input  logic                        cfg_valid,
    output logic                        cfg_ready,
    input  csr_index_pkg::index_t       cfg_index_start,
    input  csr_index_pkg::index_t       cfg_index_end,
    input  csr_index_pkg::stride_t      cfg_stride,
    input  logic                        cfg_shift_left,
    input  csr_index_pkg::shift_amt_t   cfg_shift_amount,
    input  csr_request_pkg::route_t     cfg_route,
    input  logic                        pause,
    input  logic                        fifo_empty,
    output logic                        done,
    index_step_if.sequencer             step_if,
    request_push_if.sequencer           push_if
);
    import csr_index_pkg::*;
    import csr_request_pkg::*;

    gen_state_t state;
    gen_state_t next_state;

    index_t     start_r;
    index_t     end_r;
    stride_t    stride_r;
    logic       shift_left_r;
    shift_amt_t shift_amt_r;
    route_t     route_r;

    logic       accept;
    logic       issue;
    addr_t      offset;

    // cfg_ready is only high while idle
    assign accept = cfg_valid & cfg_ready;

    always_ff @(posedge ap_clk) begin
        if (accept) begin
            start_r      <= cfg_index_start;
            end_r        <= cfg_index_end;
            stride_r     <= cfg_stride;
            shift_left_r <= cfg_shift_left;
            shift_amt_r  <= cfg_shift_amount;
            route_r      <= cfg_route;
        end
    end

    // ------------------------------
    // State machine
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            state <= RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            RESET: next_state = IDLE;
            IDLE:  if (accept) next_state = LOAD;
            LOAD:  next_state = RUN;
            RUN: begin
                if (step_if.at_end) begin
                    next_state = DONE;
                end else if (push_if.above_thresh || pause) begin
                    next_state = HOLD;
                end
            end
            HOLD:  if (!push_if.above_thresh && !pause) next_state = RUN;
            DONE:  next_state = IDLE;
            default: next_state = RESET;
        endcase
    end

    // One index per cycle while running and unblocked
    assign issue = (state == RUN) & ~step_if.at_end & ~push_if.above_thresh & ~pause;

    assign step_if.load   = (state == LOAD);
    assign step_if.start  = start_r;
    assign step_if.limit  = end_r;
    assign step_if.stride = stride_r;
    assign step_if.step   = issue;

    // Address offset from the current count
    assign offset = shift_left_r ? (step_if.count << shift_amt_r)
                                 : (step_if.count >> shift_amt_r);

    // ------------------------------
    // Request and status registers
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        push_if.index  <= step_if.count;
        push_if.base   <= start_r;
        push_if.offset <= offset;
        push_if.route  <= route_r;
    end

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            push_if.push <= 1'b0;
            cfg_ready    <= 1'b0;
            done         <= 1'b0;
        end else begin
            push_if.push <= issue;
            cfg_ready    <= (state == IDLE) & ~accept;
            // Run is over once idle with nothing left queued
            done         <= (state == IDLE) & ~accept & fifo_empty;
        end
    end

    // Every pushed index lies below the range end
    assert property (@(posedge ap_clk) disable iff (areset_engine)
        push_if.push |-> push_if.index < end_r);

endmodule

// ==== source/index_stride_counter.sv ====
// Loadable stride counter with end-of-range detection
`timescale 1ns/10ps

module index_stride_counter (
    input  logic            ap_clk,
    input  logic            areset_engine,
    index_step_if.counter   step_if
);
    import csr_index_pkg::*;

    stride_t                stride_r;
    index_t                 limit_r;
    logic                   wrapped;
    logic [INDEX_WIDTH:0]   sum;

    // Carry out of the add means the range end was passed
    assign sum = {1'b0, step_if.count} + stride_r;

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            step_if.count <= '0;
            limit_r       <= '0;
            wrapped       <= 1'b0;
        end else if (step_if.load) begin
            step_if.count <= step_if.start;
            limit_r       <= step_if.limit;
            wrapped       <= 1'b0;
        end else if (step_if.step) begin
            step_if.count <= sum[INDEX_WIDTH-1:0];
            wrapped       <= wrapped | sum[INDEX_WIDTH];
        end
    end

    always_ff @(posedge ap_clk) begin
        if (step_if.load) begin
            stride_r <= step_if.stride;
        end
    end

    assign step_if.at_end = wrapped | (step_if.count >= limit_r);

    // A zero stride from the configuration would never reach the end
    assert property (@(posedge ap_clk) disable iff (areset_engine)
        step_if.load |-> step_if.stride != '0);

endmodule

// ==== source/request_push_if.sv ====
// Push port from the sequencer into the request FIFO
`timescale 1ns/10ps

interface request_push_if;
    import csr_index_pkg::*;
    import csr_request_pkg::*;

    // Request written by the sequencer
    logic   push;
    index_t index;
    addr_t  base;
    addr_t  offset;
    route_t route;

    // Registered occupancy flag from the FIFO
    logic   above_thresh;

    modport sequencer (output push, index, base, offset, route, input above_thresh);

    modport fifo (input push, index, base, offset, route, output above_thresh);

endinterface

// ==== source/index_step_if.sv ====
// Load and step handshake between the sequencer and the stride counter
`timescale 1ns/10ps

interface index_step_if;
    import csr_index_pkg::*;

    // Driven by the sequencer
    logic    load;
    index_t  start;
    stride_t stride;
    index_t  limit;
    logic    step;

    // Driven by the counter
    index_t  count;
    logic    at_end;

    modport sequencer (output load, start, stride, limit, step, input count, at_end);

    modport counter (input load, start, stride, limit, step, output count, at_end);

endinterface

// ==== source/csr_request_pkg.sv ====
// Route and address types of the outgoing read request

package csr_request_pkg;

    // Destination tag width
    parameter int ROUTE_WIDTH = 8;

    // Base and offset address width
    parameter int ADDR_WIDTH = 32;

    // ------------------------------
    // Request fields
    // ------------------------------

    // Copied unchanged from the run configuration
    typedef logic [ROUTE_WIDTH-1:0] route_t;

    // Base is the range start, offset is the shifted index
    typedef logic [ADDR_WIDTH-1:0] addr_t;

endpackage

// ==== source/csr_index_pkg.sv ====
// Index, stride and shift types for the CSR index generator
// Sequencer state encoding

package csr_index_pkg;

    // Vertex and edge index width
    parameter int INDEX_WIDTH = 32;

    typedef logic [INDEX_WIDTH-1:0] index_t;

    // Step between consecutive indices, must be nonzero
    typedef logic [15:0] stride_t;

    // Shift amount applied to the index for the address offset
    typedef logic [4:0] shift_amt_t;

    // ------------------------------
    // Sequencer states
    // ------------------------------
    typedef enum logic [2:0] {
        RESET,
        IDLE,
        LOAD,
        RUN,
        HOLD,
        DONE
    } gen_state_t;

endpackage
